// File: common/rv_pkg.sv
package rv_pkg;

    localparam int unsigned xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_e;

    // Instruction class seen by the ALU decoder
    typedef enum logic [1:0] {
        cls_add    = 2'd0,  // Address and upper-immediate math
        cls_branch = 2'd1,
        cls_imm    = 2'd2,
        cls_reg    = 2'd3
    } alu_class_e;

    typedef enum logic [1:0] {
        opa_rs1  = 2'd0,
        opa_pc   = 2'd1,
        opa_zero = 2'd2
    } opa_sel_e;

    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       mem_to_reg;
        logic       alu_src_imm;  // Second operand from immediate
        logic       branch;
        opa_sel_e   opa_sel;
        alu_class_e alu_class;
    } ctrl_t;

    // Data bus request, word accesses only
    typedef struct packed {
        logic  we;
        logic  re;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    // Programs report their result here
    localparam word_t status_addr = 32'h0000_03FC;

endpackage

// File: decode/main_decoder.sv
module main_decoder (
    input  rv_pkg::opcode_e opcode,
    output rv_pkg::ctrl_t   ctrl
);

    always_comb
    begin
        ctrl = '0;  // Unknown opcodes act as no-ops
        case (opcode)
            rv_pkg::op_load:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.opa_sel     = rv_pkg::opa_rs1;
                ctrl.alu_class   = rv_pkg::cls_add;
            end
            rv_pkg::op_store:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.opa_sel     = rv_pkg::opa_rs1;
                ctrl.alu_class   = rv_pkg::cls_add;
            end
            rv_pkg::op_branch:
            begin
                ctrl.branch      = 1'b1;
                ctrl.opa_sel     = rv_pkg::opa_rs1;
                ctrl.alu_class   = rv_pkg::cls_branch;  // Compare rs1 with rs2
            end
            rv_pkg::op_imm:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.opa_sel     = rv_pkg::opa_rs1;
                ctrl.alu_class   = rv_pkg::cls_imm;
            end
            rv_pkg::op_reg:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.opa_sel     = rv_pkg::opa_rs1;
                ctrl.alu_class   = rv_pkg::cls_reg;
            end
            rv_pkg::op_lui:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.opa_sel     = rv_pkg::opa_zero;  // 0 + U immediate
                ctrl.alu_class   = rv_pkg::cls_add;
            end
            rv_pkg::op_auipc:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.opa_sel     = rv_pkg::opa_pc;
                ctrl.alu_class   = rv_pkg::cls_add;
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: decode/alu_decoder.sv
module alu_decoder (
    input  rv_pkg::alu_class_e alu_class,
    input  logic [2:0]         funct3,
    input  logic               funct7_b5,
    output rv_pkg::alu_op_e    alu_op
);

    logic use_sub;

    // Only R-type reads bit 30 for add versus sub
    assign use_sub = (alu_class == rv_pkg::cls_reg) && funct7_b5;

    always_comb
    begin
        alu_op = rv_pkg::alu_add;
        case (alu_class)
            rv_pkg::cls_branch:
            begin
                case (funct3[2:1])
                    2'b10:   alu_op = rv_pkg::alu_slt;   // blt, bge
                    2'b11:   alu_op = rv_pkg::alu_sltu;  // bltu, bgeu
                    default: alu_op = rv_pkg::alu_sub;   // beq, bne
                endcase
            end
            rv_pkg::cls_imm, rv_pkg::cls_reg:
            begin
                case (funct3)
                    3'b000:  alu_op = use_sub ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b001:  alu_op = rv_pkg::alu_sll;
                    3'b010:  alu_op = rv_pkg::alu_slt;
                    3'b011:  alu_op = rv_pkg::alu_sltu;
                    3'b100:  alu_op = rv_pkg::alu_xor;
                    3'b101:  alu_op = funct7_b5 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110:  alu_op = rv_pkg::alu_or;
                    default: alu_op = rv_pkg::alu_and;
                endcase
            end
            default: alu_op = rv_pkg::alu_add;  // Addresses, lui, auipc
        endcase
    end

endmodule

// File: decode/imm_gen.sv
module imm_gen (
    input  rv_pkg::word_t instr,
    output rv_pkg::word_t imm
);

    rv_pkg::opcode_e opcode;

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);

    always_comb
    begin
        case (opcode)
            rv_pkg::op_load, rv_pkg::op_imm:
            begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            rv_pkg::op_store:
            begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_pkg::op_branch:
            begin
                // Offset in halfwords, bit 0 always clear
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            rv_pkg::op_lui, rv_pkg::op_auipc:
            begin
                imm = {instr[31:12], 12'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// File: src/alu.sv
module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result,
    output logic            zero
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_and:  result = a & b;
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);  // Sign fill
            rv_pkg::alu_slt:
            begin
                result = {{(rv_pkg::xlen - 1){1'b0}}, lt_signed};
            end
            rv_pkg::alu_sltu:
            begin
                result = {{(rv_pkg::xlen - 1){1'b0}}, lt_unsigned};
            end
            default:          result = '0;
        endcase
    end

    // Used by beq and bne after a subtract
    assign zero = (result == '0);

endmodule

// File: src/reg_file.sv
module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  logic              we,
    input  rv_pkg::word_t     wdata,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && rd != '0)
        begin
            regs[rd] <= wdata;
        end
    end

    // Asynchronous reads, x0 reads as zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: src/pc_unit.sv
module pc_unit #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          branch,
    input  logic [2:0]    funct3,
    input  rv_pkg::word_t imm,
    input  logic          alu_zero,
    input  logic          alu_lsb,
    output rv_pkg::word_t pc
);

    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t pc_target;
    logic          cond;
    logic          taken;

    assign pc_plus4  = pc + rv_pkg::word_t'(4);
    assign pc_target = pc + imm;

    // Branch condition from funct3
    always_comb
    begin
        case (funct3)
            3'b000:         cond = alu_zero;   // beq
            3'b001:         cond = !alu_zero;  // bne
            3'b100, 3'b110: cond = alu_lsb;    // blt, bltu
            3'b101, 3'b111: cond = !alu_lsb;   // bge, bgeu
            default:        cond = 1'b0;
        endcase
    end

    assign taken = branch && cond;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            pc <= reset_pc;
        else
            pc <= taken ? pc_target : pc_plus4;
    end

endmodule

// File: src/rv_core.sv
module rv_core #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::word_t     instr,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::word_t     pc,
    output rv_pkg::dmem_req_t dmem_req
);

    rv_pkg::ctrl_t     ctrl;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::word_t     imm;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     opa;
    rv_pkg::word_t     opb;
    rv_pkg::word_t     alu_result;
    rv_pkg::word_t     wb_data;
    logic              alu_zero;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    pc_unit #(
        .reset_pc (reset_pc)
    ) i_pc_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .branch   (ctrl.branch),
        .funct3   (instr[14:12]),
        .imm      (imm),
        .alu_zero (alu_zero),
        .alu_lsb  (alu_result[0]),  // Compare bit of slt/sltu
        .pc       (pc)
    );

    main_decoder i_main_decoder (
        .opcode (rv_pkg::opcode_e'(instr[6:0])),
        .ctrl   (ctrl)
    );

    alu_decoder i_alu_decoder (
        .alu_class (ctrl.alu_class),
        .funct3    (instr[14:12]),
        .funct7_b5 (instr[30]),
        .alu_op    (alu_op)
    );

    imm_gen i_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .we     (ctrl.reg_write),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // First operand: rs1, pc for auipc, zero for lui
    always_comb
    begin
        case (ctrl.opa_sel)
            rv_pkg::opa_pc:   opa = pc;
            rv_pkg::opa_zero: opa = '0;
            default:          opa = rs1_data;
        endcase
    end

    assign opb = ctrl.alu_src_imm ? imm : rs2_data;

    alu i_alu (
        .a      (opa),
        .b      (opb),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign wb_data = ctrl.mem_to_reg ? dmem_rdata : alu_result;

    // No strobes reach memory while in reset
    always_comb
    begin
        dmem_req.we    = ctrl.mem_write && arst_n;
        dmem_req.re    = ctrl.mem_read && arst_n;
        dmem_req.addr  = alu_result;
        dmem_req.wdata = rs2_data;
    end

endmodule

// File: dv/rv_core_chk.sv
module rv_core_chk #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input logic              clk,
    input logic              arst_n,
    input rv_pkg::word_t     pc,
    input rv_pkg::word_t     instr,
    input rv_pkg::dmem_req_t dmem_req
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned   fail_count = 0;
    rv_pkg::word_t b_offset;
    logic          is_branch;

    assign b_offset  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign is_branch = (instr[6:0] == rv_pkg::op_branch);

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (pc == reset_pc && !dmem_req.we && !dmem_req.re))
        else begin $error("pc or strobes wrong in reset"); fail_count++; end

    a_reset_release: assert property (@(posedge clk) $rose(arst_n) |-> pc == reset_pc)
        else begin $error("pc moved in first cycle after reset"); fail_count++; end

    a_pc_seq: assert property (@(posedge clk) disable iff (!arst_n)
        !is_branch |=> pc == $past(pc) + 32'd4)
        else begin $error("next pc is not pc+4"); fail_count++; end

    a_pc_branch: assert property (@(posedge clk) disable iff (!arst_n)
        is_branch |=> (pc == $past(pc) + 32'd4 || pc == $past(pc) + $past(b_offset)))
        else begin $error("branch target out of range"); fail_count++; end

    a_status_ok: assert property (@(posedge clk) disable iff (!arst_n)
        (dmem_req.we && dmem_req.addr == rv_pkg::status_addr) |-> dmem_req.wdata == 32'd1)
        else begin $error("program stored a failure code"); fail_count++; end

    a_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (dmem_req.we || dmem_req.re) |-> dmem_req.addr[1:0] == 2'b00)
        else begin $error("misaligned data access"); fail_count++; end

endmodule

bind rv_core rv_core_chk #(.reset_pc(reset_pc)) i_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .pc       (pc),
    .instr    (instr),
    .dmem_req (dmem_req)
);

// File: dv/tb_programs.svh
// Register-register ops, summed and compared against one signature
logic [31:0] prog_reg [$] = '{
    32'h00200F13, 32'hFF800093, 32'h00B00113, 32'h002081B3,
    32'h40208233, 32'h0020F2B3, 32'h0020E333, 32'h0020C3B3,
    32'h00209433, 32'h0020D4B3, 32'h4020D533, 32'h0020A5B3,
    32'h0020B633, 32'h001136B3, 32'h00418A33, 32'h005A0A33,
    32'h006A0A33, 32'h007A0A33, 32'h008A0A33, 32'h009A0A33,
    32'h00AA0A33, 32'h00BA0A33, 32'h00CA0A33, 32'h00DA0A33,
    32'h001FCAB7, 32'hFE6A8A93, 32'h015A1863, 32'h00100E93,
    32'h3FD02E23, 32'h00000063, 32'h3FE02E23, 32'h00000063
};

// I-type ops plus lui and auipc
logic [31:0] prog_imm [$] = '{
    32'h00200F13, 32'hFF800093, 32'h00F0F193, 32'h0050E213,
    32'hFFF0C293, 32'h00409313, 32'h01C0D393, 32'h4020D413,
    32'hFF90A493, 32'h0050B513, 32'h06408593, 32'h12345637,
    32'h00001697, 32'h00418A33, 32'h005A0A33, 32'h006A0A33,
    32'h007A0A33, 32'h008A0A33, 32'h009A0A33, 32'h00AA0A33,
    32'h00BA0A33, 32'h00CA0A33, 32'h00DA0A33, 32'h12346AB7,
    32'h026A8A93, 32'h015A1863, 32'h00100E93, 32'h3FD02E23,
    32'h00000063, 32'h3FE02E23, 32'h00000063
};

// Copy word 0x100 to 0x104 and read it back
logic [31:0] prog_mem [$] = '{
    32'h00200F13, 32'h10002083, 32'h10102223, 32'h10402103,
    32'h00209863, 32'h00100E93, 32'h3FD02E23, 32'h00000063,
    32'h3FE02E23, 32'h00000063
};

// Each condition: taken skips a fail store, not taken hops over one
logic [31:0] prog_branch [$] = '{
    32'h00200F13, 32'hFFF00093, 32'h00100113,
    32'h00108463, 32'h3FE02E23, 32'h00208463, 32'h00000463, 32'h3FE02E23,
    32'h00209463, 32'h3FE02E23, 32'h00109463, 32'h00000463, 32'h3FE02E23,
    32'h0020C463, 32'h3FE02E23, 32'h00114463, 32'h00000463, 32'h3FE02E23,
    32'h00115463, 32'h3FE02E23, 32'h0020D463, 32'h00000463, 32'h3FE02E23,
    32'h00116463, 32'h3FE02E23, 32'h0020E463, 32'h00000463, 32'h3FE02E23,
    32'h0020F463, 32'h3FE02E23, 32'h00117463, 32'h00000463, 32'h3FE02E23,
    32'h00100E93, 32'h3FD02E23, 32'h00000063
};

// jal and an all-ones word must leave x1 untouched
logic [31:0] prog_nop [$] = '{
    32'h00200F13, 32'h00500093, 32'h008000EF, 32'hFFFFFFFF,
    32'h00500113, 32'h00209863, 32'h00100E93, 32'h3FD02E23,
    32'h00000063, 32'h3FE02E23, 32'h00000063
};

function automatic logic [31:0] prog_word(input int p, input int i);
    case (p)
        0: return (i < prog_reg.size()) ? prog_reg[i] : 32'h0;
        1: return (i < prog_imm.size()) ? prog_imm[i] : 32'h0;
        2: return (i < prog_mem.size()) ? prog_mem[i] : 32'h0;
        3: return (i < prog_branch.size()) ? prog_branch[i] : 32'h0;
        default: return (i < prog_nop.size()) ? prog_nop[i] : 32'h0;
    endcase
endfunction

function automatic string prog_name(input int p);
    case (p)
        0: return "reg_reg";
        1: return "reg_imm";
        2: return "load_store";
        3: return "branch";
        default: return "unknown_opcode";
    endcase
endfunction

// File: dv/tb_top.sv
module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_tests   = 5;
    localparam int rst_cycles  = 10;
    localparam int cycle_limit = num_tests * 64 * 2 + num_tests * rst_cycles;

    logic              clk = 1'b0;
    logic              arst_n;
    rv_pkg::word_t     instr;
    rv_pkg::word_t     dmem_rdata;
    rv_pkg::word_t     pc;
    rv_pkg::dmem_req_t dmem_req;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic        status_seen;
    logic [31:0] status_val;
    int          cycles = 0;
    int          passes = 0;
    int          fails = 0;

    `include "tb_programs.svh"

    always #5 clk = ~clk;

    rv_core #(
        .reset_pc ('0)
    ) i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .dmem_rdata (dmem_rdata),
        .pc         (pc),
        .dmem_req   (dmem_req)
    );

    assign instr      = rom[pc[9:2]];
    assign dmem_rdata = ram[dmem_req.addr[9:2]];

    // Data RAM, refilled with random words on every reset
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 256; i++)
                ram[i] <= $urandom();
            ram[255]    <= '0;  // Status word
            status_seen <= 1'b0;
        end
        else if (dmem_req.we)
        begin
            ram[dmem_req.addr[9:2]] <= dmem_req.wdata;
            if (dmem_req.addr == rv_pkg::status_addr)
            begin
                status_seen <= 1'b1;
                status_val  <= dmem_req.wdata;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("Timeout: no status store within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic load_program(input int p);
        for (int i = 0; i < 256; i++)
            rom[i] = prog_word(p, i);
    endtask

    task automatic run_program(input int p);
        @(negedge clk);
        arst_n = 1'b0;
        // Memory ops at pc 0 while held in reset must not strobe
        rom[0] = 32'h10002083;  // lw x1, 0x100(x0)
        repeat (2) @(negedge clk);
        rom[0] = 32'h10102223;  // sw x1, 0x104(x0)
        repeat (2) @(negedge clk);
        load_program(p);
        repeat (rst_cycles - 4) @(negedge clk);
        arst_n = 1'b1;
        while (!status_seen)
            @(negedge clk);
        if (status_val !== 32'd1)
        begin
            $display("FAILED at %0d ns: %s stored status %0d", $time, prog_name(p), status_val);
            fails++;
        end
        else
        begin
            $display("test %s ok", prog_name(p));
            passes++;
        end
    endtask

    initial
    begin
        void'($urandom(32'h2225));
        arst_n = 1'b0;
        load_program(0);
        for (int p = 0; p < num_tests; p++)
            run_program(p);
        $display("Tests ok: %0d, failed: %0d, assertion failures: %0d",
                 passes, fails, i_dut.i_chk.fail_count);
        if (fails == 0 && i_dut.i_chk.fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+dv
common/rv_pkg.sv
decode/main_decoder.sv
decode/alu_decoder.sv
decode/imm_gen.sv
src/alu.sv
src/reg_file.sv
src/pc_unit.sv
src/rv_core.sv
dv/rv_core_chk.sv
dv/tb_top.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f flist.f --top-module tb_top -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "sim passed" sim.log || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
